//--- include/pspin_sched_macros.svh
//////////////////////////////////////////////////////////////////////
// Scheduler sizes and widths
//////////////////////////////////////////////////////////////////////

`ifndef PSPIN_SCHED_MACROS_SVH
`define PSPIN_SCHED_MACROS_SVH

// Clusters served by the dispatcher
`define NUM_CLUSTERS 4

// Tasks a single cluster may hold at once
`define NUM_HERS_PER_CLUSTER 2

// Depth of the inbound HER queue
`define HER_SLOTS 8

// Message identifier width
`define MSGID_W 10

// Handler and packet address width
`define ADDR_W 32

// Packet size in bytes
`define SIZE_W 16

`endif

//--- source/pspin_sched_pkg.sv
//////////////////////////////////////////////////////////////////////
// Scheduler types
//////////////////////////////////////////////////////////////////////

`include "pspin_sched_macros.svh"

package pspin_sched_pkg;

  // Index of a cluster
  typedef logic [$clog2(`NUM_CLUSTERS)-1:0] cluster_id_t;

  // Outstanding tasks on one cluster, 0 up to the limit
  typedef logic [$clog2(`NUM_HERS_PER_CLUSTER+1)-1:0] credit_t;

  // One handler execution request from the NIC inbound side
  typedef struct packed {
    logic [`MSGID_W-1:0] msgid;
    logic [`ADDR_W-1:0]  handler_addr;
    logic [`ADDR_W-1:0]  pkt_addr;
    logic [`SIZE_W-1:0]  pkt_size;
  } her_descr_t;

  // HER together with the cluster it was placed on
  typedef struct packed {
    her_descr_t  her;
    cluster_id_t cluster_id;
  } handler_task_t;

  // Completion report of a finished task
  typedef struct packed {
    logic [`MSGID_W-1:0] msgid;
    logic [`ADDR_W-1:0]  pkt_addr;
  } feedback_descr_t;

endpackage

//--- source/her_queue.sv
//////////////////////////////////////////////////////////////////////
// HER descriptor queue
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pspin_sched_macros.svh"

module her_queue
  import pspin_sched_pkg::*;
(
  input  logic       clk_i,
  input  logic       arst_n_i,

  // From NIC inbound
  input  logic       push_valid_i,
  output logic       push_ready_o,
  input  her_descr_t push_her_i,

  // To dispatcher
  output logic       pop_valid_o,
  input  logic       pop_ready_i,
  output her_descr_t pop_her_o
);

  typedef logic [$clog2(`HER_SLOTS)-1:0]   ptr_t;
  typedef logic [$clog2(`HER_SLOTS+1)-1:0] fill_t;

  her_descr_t mem_q [`HER_SLOTS];
  ptr_t       wr_ptr_q;
  ptr_t       rd_ptr_q;
  fill_t      count_q;
  logic       push_hs;
  logic       pop_hs;

  // Full only when every slot is taken
  assign push_ready_o = (count_q != fill_t'(`HER_SLOTS));
  assign pop_valid_o  = (count_q != '0);
  assign pop_her_o    = mem_q[rd_ptr_q];

  assign push_hs = push_valid_i && push_ready_o;
  assign pop_hs  = pop_valid_o && pop_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_hs) begin
        wr_ptr_q <= (wr_ptr_q == ptr_t'(`HER_SLOTS - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_hs) begin
        rd_ptr_q <= (rd_ptr_q == ptr_t'(`HER_SLOTS - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // Fill count follows the two handshakes
      case ({push_hs, pop_hs})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push_hs) begin
      mem_q[wr_ptr_q] <= push_her_i;
    end
  end

  // A full queue has met pointers and its write pointer stays put
  a_no_overflow: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    (count_q == fill_t'(`HER_SLOTS)) |=>
      $stable(wr_ptr_q) && $past(wr_ptr_q == rd_ptr_q)
  );

endmodule

//--- source/cluster_dispatcher.sv
//////////////////////////////////////////////////////////////////////
// Round-robin task dispatcher
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pspin_sched_macros.svh"

module cluster_dispatcher
  import pspin_sched_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,

  // Head of the HER queue
  input  logic                     her_valid_i,
  output logic                     her_ready_o,
  input  her_descr_t               her_i,

  // Task ports toward the clusters
  output logic [`NUM_CLUSTERS-1:0] task_valid_o,
  input  logic [`NUM_CLUSTERS-1:0] task_ready_i,
  output handler_task_t            task_o,

  // One pulse per finished task, from the feedback arbiter
  input  logic [`NUM_CLUSTERS-1:0] release_i
);

  credit_t [`NUM_CLUSTERS-1:0] occ_q;
  logic    [`NUM_CLUSTERS-1:0] occ_free;
  logic    [`NUM_CLUSTERS-1:0] task_hs;
  cluster_id_t                 rr_q;
  cluster_id_t                 pick;
  logic                        pick_found;
  logic                        task_valid_q;
  handler_task_t               task_q;
  logic                        slot_free;
  logic                        her_hs;

  // Only the target cluster sees a valid
  always_comb begin
    for (int c = 0; c < `NUM_CLUSTERS; c++) begin
      task_valid_o[c] = task_valid_q && (task_q.cluster_id == cluster_id_t'(c));
    end
  end

  assign task_o  = task_q;
  assign task_hs = task_valid_o & task_ready_i;

  // A task parked in the register already counts against its cluster
  always_comb begin
    logic [$bits(credit_t):0] occ_ext;
    for (int c = 0; c < `NUM_CLUSTERS; c++) begin
      occ_ext     = {1'b0, occ_q[c]} + {{$bits(credit_t){1'b0}}, task_valid_o[c]};
      occ_free[c] = (occ_ext < `NUM_HERS_PER_CLUSTER);
    end
  end

  // First cluster with room after the last one chosen
  always_comb begin
    cluster_id_t idx;
    pick       = rr_q;
    pick_found = 1'b0;
    for (int i = 1; i <= `NUM_CLUSTERS; i++) begin
      idx = cluster_id_t'((int'(rr_q) + i) % `NUM_CLUSTERS);
      if (!pick_found && occ_free[idx]) begin
        pick       = idx;
        pick_found = 1'b1;
      end
    end
  end

  // Register is refilled when empty or being emptied
  assign slot_free   = !task_valid_q || (|task_hs);
  assign her_ready_o = slot_free && pick_found;
  assign her_hs      = her_valid_i && her_ready_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      task_valid_q <= 1'b0;
      rr_q         <= cluster_id_t'(`NUM_CLUSTERS - 1);
    end else if (her_hs) begin
      task_valid_q <= 1'b1;
      rr_q         <= pick;
    end else if (|task_hs) begin
      task_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (her_hs) begin
      task_q.her        <= her_i;
      task_q.cluster_id <= pick;
    end
  end

  // Occupancy up on dispatch, down on release
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      occ_q <= '0;
    end else begin
      for (int c = 0; c < `NUM_CLUSTERS; c++) begin
        case ({task_hs[c], release_i[c]})
          2'b10:   occ_q[c] <= occ_q[c] + 1'b1;
          2'b01:   occ_q[c] <= occ_q[c] - 1'b1;
          default: occ_q[c] <= occ_q[c];
        endcase
      end
    end
  end

  for (genvar c = 0; c < `NUM_CLUSTERS; c++) begin : gen_checks
    a_occ_max: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      occ_q[c] <= `NUM_HERS_PER_CLUSTER
    );
    // Feedback never arrives for a cluster with nothing outstanding
    a_occ_no_wrap: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      release_i[c] |-> (occ_q[c] != '0)
    );
    a_task_stable: assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      task_valid_o[c] && !task_ready_i[c] |=> task_valid_o[c] && $stable(task_o)
    );
  end

endmodule

//--- source/feedback_arbiter.sv
//////////////////////////////////////////////////////////////////////
// Cluster feedback arbiter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pspin_sched_macros.svh"

module feedback_arbiter
  import pspin_sched_pkg::*;
(
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,

  // From the clusters
  input  logic            [`NUM_CLUSTERS-1:0]    cl_fb_valid_i,
  output logic            [`NUM_CLUSTERS-1:0]    cl_fb_ready_o,
  input  feedback_descr_t [`NUM_CLUSTERS-1:0]    cl_fb_i,

  // To NIC inbound
  output logic                                   nic_fb_valid_o,
  input  logic                                   nic_fb_ready_i,
  output feedback_descr_t                        nic_fb_o,

  // Frees one slot of the cluster in the dispatcher
  output logic            [`NUM_CLUSTERS-1:0]    release_o
);

  cluster_id_t                rr_q;
  cluster_id_t                gnt;
  logic                       gnt_found;
  logic                       take;
  logic [`NUM_CLUSTERS-1:0]   fb_hs;
  logic                       fb_valid_q;
  feedback_descr_t            fb_q;

  // Output register empty or draining this cycle
  assign take = !fb_valid_q || nic_fb_ready_i;

  // Next requesting cluster after the last grant
  always_comb begin
    cluster_id_t idx;
    gnt       = rr_q;
    gnt_found = 1'b0;
    for (int i = 1; i <= `NUM_CLUSTERS; i++) begin
      idx = cluster_id_t'((int'(rr_q) + i) % `NUM_CLUSTERS);
      if (!gnt_found && cl_fb_valid_i[idx]) begin
        gnt       = idx;
        gnt_found = 1'b1;
      end
    end
  end

  always_comb begin
    cl_fb_ready_o = '0;
    if (take && gnt_found) begin
      cl_fb_ready_o[gnt] = 1'b1;
    end
  end

  assign fb_hs     = cl_fb_valid_i & cl_fb_ready_o;
  assign release_o = fb_hs;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fb_valid_q <= 1'b0;
      rr_q       <= cluster_id_t'(`NUM_CLUSTERS - 1);
    end else if (|fb_hs) begin
      fb_valid_q <= 1'b1;
      rr_q       <= gnt;
    end else if (nic_fb_ready_i) begin
      fb_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (|fb_hs) begin
      fb_q <= cl_fb_i[gnt];
    end
  end

  assign nic_fb_valid_o = fb_valid_q;
  assign nic_fb_o       = fb_q;

  a_ready_onehot: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(cl_fb_ready_o)
  );

  // NIC stall freezes the register and blocks every cluster
  a_stall_hold: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
    nic_fb_valid_o && !nic_fb_ready_i |=>
      nic_fb_valid_o && $stable(nic_fb_o) && ($past(cl_fb_ready_o) == '0)
  );

endmodule

//--- source/pspin_sched_top.sv
//////////////////////////////////////////////////////////////////////
// Inter-cluster scheduler top
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pspin_sched_macros.svh"

module pspin_sched_top
  import pspin_sched_pkg::*;
(
  input  logic                                   clk_i,
  input  logic                                   arst_n_i,

  // From NIC inbound
  input  logic                                   her_valid_i,
  output logic                                   her_ready_o,
  input  her_descr_t                             her_i,

  // Tasks to the clusters
  output logic            [`NUM_CLUSTERS-1:0]    cluster_task_valid_o,
  input  logic            [`NUM_CLUSTERS-1:0]    cluster_task_ready_i,
  output handler_task_t                          cluster_task_o,

  // Feedback from the clusters
  input  logic            [`NUM_CLUSTERS-1:0]    cluster_fb_valid_i,
  output logic            [`NUM_CLUSTERS-1:0]    cluster_fb_ready_o,
  input  feedback_descr_t [`NUM_CLUSTERS-1:0]    cluster_fb_i,

  // To NIC inbound
  output logic                                   nic_feedback_valid_o,
  input  logic                                   nic_feedback_ready_i,
  output feedback_descr_t                        nic_feedback_o,

  // Cluster activity
  input  logic            [`NUM_CLUSTERS-1:0]    cluster_active_i,
  output logic                                   pspin_active_o
);

  // Queue head -> dispatcher
  logic                     head_valid;
  logic                     head_ready;
  her_descr_t               head_her;

  // Arbiter -> dispatcher slot release
  logic [`NUM_CLUSTERS-1:0] fb_release;

  // High once every cluster is up
  assign pspin_active_o = &cluster_active_i;

  her_queue i_her_queue (
    .clk_i        ( clk_i        ),
    .arst_n_i     ( arst_n_i     ),
    .push_valid_i ( her_valid_i  ),
    .push_ready_o ( her_ready_o  ),
    .push_her_i   ( her_i        ),
    .pop_valid_o  ( head_valid   ),
    .pop_ready_i  ( head_ready   ),
    .pop_her_o    ( head_her     )
  );

  cluster_dispatcher i_cluster_dispatcher (
    .clk_i        ( clk_i                ),
    .arst_n_i     ( arst_n_i             ),
    .her_valid_i  ( head_valid           ),
    .her_ready_o  ( head_ready           ),
    .her_i        ( head_her             ),
    .task_valid_o ( cluster_task_valid_o ),
    .task_ready_i ( cluster_task_ready_i ),
    .task_o       ( cluster_task_o       ),
    .release_i    ( fb_release           )
  );

  feedback_arbiter i_feedback_arbiter (
    .clk_i          ( clk_i                ),
    .arst_n_i       ( arst_n_i             ),
    .cl_fb_valid_i  ( cluster_fb_valid_i   ),
    .cl_fb_ready_o  ( cluster_fb_ready_o   ),
    .cl_fb_i        ( cluster_fb_i         ),
    .nic_fb_valid_o ( nic_feedback_valid_o ),
    .nic_fb_ready_i ( nic_feedback_ready_i ),
    .nic_fb_o       ( nic_feedback_o       ),
    .release_o      ( fb_release           )
  );

endmodule

//--- dv/tb_cluster_model.sv
//////////////////////////////////////////////////////////////////////
// Behavioral cluster model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pspin_sched_macros.svh"

module tb_cluster_model
  import pspin_sched_pkg::*;
(
  input  logic            clk_i,
  input  logic            arst_n_i,
  input  logic            hold_i,
  input  logic            task_valid_i,
  output logic            task_ready_o,
  input  handler_task_t   task_i,
  output logic            fb_valid_o,
  input  logic            fb_ready_i,
  output feedback_descr_t fb_o
);

  // Tasks still running, oldest first
  feedback_descr_t pend_q[$];
  int unsigned     delay;

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      task_ready_o <= 1'b0;
      fb_valid_o   <= 1'b0;
      fb_o         <= '0;
      delay        <= 0;
      pend_q.delete();
    end else begin
      task_ready_o <= !hold_i && ($urandom_range(3) != 0);
      if (task_valid_i && task_ready_o) begin
        pend_q.push_back('{msgid: task_i.her.msgid, pkt_addr: task_i.her.pkt_addr});
      end
      if (fb_valid_o && fb_ready_i) begin
        fb_valid_o <= 1'b0;
        delay      <= $urandom_range(12, 1);
      end else if (!fb_valid_o && (pend_q.size() != 0)) begin
        // Task finishes once its run time is used up
        if (delay == 0) begin
          fb_valid_o <= 1'b1;
          fb_o       <= pend_q.pop_front();
        end else begin
          delay <= delay - 1;
        end
      end
    end
  end

endmodule

//--- dv/tb_pspin_sched.sv
//////////////////////////////////////////////////////////////////////
// Scheduler testbench
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "pspin_sched_macros.svh"

module tb_pspin_sched
  import pspin_sched_pkg::*;
();

  localparam int MAX_CYCLES = 4000;

  logic                                clk_i = 1'b0;
  logic                                arst_n_i;
  logic                                her_valid_i = 1'b0;
  logic                                her_ready_o;
  her_descr_t                          her_i = '0;
  logic            [`NUM_CLUSTERS-1:0] cluster_task_valid_o;
  logic            [`NUM_CLUSTERS-1:0] cluster_task_ready_i;
  handler_task_t                       cluster_task_o;
  logic            [`NUM_CLUSTERS-1:0] cluster_fb_valid_i;
  logic            [`NUM_CLUSTERS-1:0] cluster_fb_ready_o;
  feedback_descr_t [`NUM_CLUSTERS-1:0] cluster_fb_i;
  logic                                nic_feedback_valid_o;
  logic                                nic_feedback_ready_i = 1'b0;
  feedback_descr_t                     nic_feedback_o;
  logic            [`NUM_CLUSTERS-1:0] cluster_active_i = '0;
  logic                                pspin_active_o;

  logic                     hold = 1'b0;
  logic                     nic_stall = 1'b0;
  logic                     bp_phase = 1'b0;
  int                       bp_accepted = 0;
  int                       errors = 0;
  int                       cycles = 0;
  logic [`MSGID_W-1:0]      msg_cnt = 1;

  // Scoreboard state
  her_descr_t               exp_q[$];
  her_descr_t               exp_head;
  int                       exp_size;
  int                       outst [`NUM_CLUSTERS];
  int                       pending_cnt;
  logic                     fb_pending [2**`MSGID_W];
  logic [`ADDR_W-1:0]       fb_addr [2**`MSGID_W];
  logic                     fb_known;
  logic [`ADDR_W-1:0]       fb_exp_addr;

  logic [`NUM_CLUSTERS-1:0] task_hs;
  logic [`NUM_CLUSTERS-1:0] fb_hs;
  logic                     nic_hs;

  always #10 clk_i = ~clk_i;

  pspin_sched_top dut_i (.*);

  for (genvar c = 0; c < `NUM_CLUSTERS; c++) begin : gen_cluster
    tb_cluster_model i_cluster (
      .clk_i        ( clk_i                   ),
      .arst_n_i     ( arst_n_i                ),
      .hold_i       ( hold                    ),
      .task_valid_i ( cluster_task_valid_o[c] ),
      .task_ready_o ( cluster_task_ready_i[c] ),
      .task_i       ( cluster_task_o          ),
      .fb_valid_o   ( cluster_fb_valid_i[c]   ),
      .fb_ready_i   ( cluster_fb_ready_o[c]   ),
      .fb_o         ( cluster_fb_i[c]         )
    );
  end

  assign task_hs = cluster_task_valid_o & cluster_task_ready_i;
  assign fb_hs   = cluster_fb_valid_i & cluster_fb_ready_o;
  assign nic_hs  = nic_feedback_valid_o && nic_feedback_ready_i;

  always_comb begin
    fb_known    = fb_pending[nic_feedback_o.msgid];
    fb_exp_addr = fb_addr[nic_feedback_o.msgid];
  end

  // NIC readiness and activity pattern change every cycle
  always @(posedge clk_i) begin
    cluster_active_i     <= $urandom_range((1 << `NUM_CLUSTERS) - 1);
    nic_feedback_ready_i <= !nic_stall && ($urandom_range(3) != 0);
  end

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exp_q.delete();
      exp_head    <= '0;
      exp_size    <= 0;
      pending_cnt <= 0;
      for (int c = 0; c < `NUM_CLUSTERS; c++) begin
        outst[c] <= 0;
      end
      for (int m = 0; m < 2**`MSGID_W; m++) begin
        fb_pending[m] <= 1'b0;
        fb_addr[m]    <= '0;
      end
    end else begin
      if (her_valid_i && her_ready_o) begin
        exp_q.push_back(her_i);
        fb_addr[her_i.msgid] <= her_i.pkt_addr;
        if (bp_phase) begin
          bp_accepted <= bp_accepted + 1;
        end
      end
      for (int c = 0; c < `NUM_CLUSTERS; c++) begin
        if (task_hs[c]) begin
          void'(exp_q.pop_front());
          fb_pending[cluster_task_o.her.msgid] <= 1'b1;
        end
        outst[c] <= outst[c] + int'(task_hs[c]) - int'(fb_hs[c]);
      end
      if (nic_hs) begin
        fb_pending[nic_feedback_o.msgid] <= 1'b0;
      end
      pending_cnt <= pending_cnt + int'(|task_hs) - int'(nic_hs);
      exp_head    <= (exp_q.size() != 0) ? exp_q[0] : '0;
      exp_size    <= exp_q.size();
    end
  end

  a_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> her_ready_o && (cluster_task_valid_o == '0) && !nic_feedback_valid_o)
    else begin
      errors++;
      $display("FAILED reset: expected ready 1 task_valid 0 fb_valid 0, actual %0b %b %0b",
               $sampled(her_ready_o), $sampled(cluster_task_valid_o),
               $sampled(nic_feedback_valid_o));
    end

  a_order: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    |task_hs |-> (exp_size > 0) && (cluster_task_o.her == exp_head))
    else begin
      errors++;
      $display("FAILED order: expected HER %h, actual %h",
               $sampled(exp_head), $sampled(cluster_task_o.her));
    end

  a_target: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    |cluster_task_valid_o |-> cluster_task_valid_o == (1 << cluster_task_o.cluster_id))
    else begin
      errors++;
      $display("FAILED target: expected valid %b, actual %b",
               4'(1 << $sampled(cluster_task_o.cluster_id)), $sampled(cluster_task_valid_o));
    end

  for (genvar c = 0; c < `NUM_CLUSTERS; c++) begin : gen_occ
    a_occupancy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      outst[c] <= `NUM_HERS_PER_CLUSTER)
      else begin
        errors++;
        $display("FAILED occupancy: cluster %0d expected at most %0d, actual %0d",
                 c, `NUM_HERS_PER_CLUSTER, $sampled(outst[c]));
      end
  end

  a_backpressure: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bp_phase |-> (her_ready_o == (bp_accepted < `HER_SLOTS + 1)))
    else begin
      errors++;
      $display("FAILED backpressure: after %0d HERs expected her_ready_o %0b, actual %0b",
               $sampled(bp_accepted), $sampled(bp_accepted) < `HER_SLOTS + 1,
               $sampled(her_ready_o));
    end

  a_nic_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    nic_feedback_valid_o && !nic_feedback_ready_i |=>
      nic_feedback_valid_o && $stable(nic_feedback_o))
    else begin
      errors++;
      $display("NIC feedback changed or dropped while the NIC was stalled");
    end

  a_fb_once: assert property (@(posedge clk_i) disable iff (!arst_n_i) nic_hs |-> fb_known)
    else begin
      errors++;
      $display("Feedback for msgid %0d arrived without an outstanding task",
               $sampled(nic_feedback_o.msgid));
    end

  a_fb_addr: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    nic_hs |-> nic_feedback_o.pkt_addr == fb_exp_addr)
    else begin
      errors++;
      $display("FAILED feedback: msgid %0d expected pkt_addr %h, actual %h",
               $sampled(nic_feedback_o.msgid), $sampled(fb_exp_addr),
               $sampled(nic_feedback_o.pkt_addr));
    end

  // Active only when no cluster bit is low
  a_active: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pspin_active_o == (cluster_active_i == {`NUM_CLUSTERS{1'b1}}))
    else begin
      errors++;
      $display("FAILED active: expected %0b, actual %0b",
               $sampled(cluster_active_i) == {`NUM_CLUSTERS{1'b1}},
               $sampled(pspin_active_o));
    end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("Test failed");
      $finish;
    end
  end

  // Offers one HER after a gap and holds it until accepted
  task automatic send_her(input int gap);
    her_descr_t h;
    repeat (gap) @(posedge clk_i);
    h.msgid        = msg_cnt;
    h.handler_addr = $urandom;
    h.pkt_addr     = $urandom;
    h.pkt_size     = $urandom;
    her_valid_i <= 1'b1;
    her_i       <= h;
    @(posedge clk_i);
    while (!her_ready_o) @(posedge clk_i);
    her_valid_i <= 1'b0;
    msg_cnt = msg_cnt + 1'b1;
  endtask

  task automatic wait_drained();
    @(posedge clk_i);
    while ((exp_size != 0) || (pending_cnt != 0)) @(posedge clk_i);
  endtask

  initial begin
    void'($urandom(96));
    arst_n_i <= 1'b0;
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    repeat (2) @(posedge clk_i);
    // Mixed traffic
    for (int i = 0; i < 24; i++) begin
      send_her($urandom_range(3));
    end
    wait_drained();
    // Clusters refuse tasks, queue and dispatcher register fill up
    hold <= 1'b1;
    repeat (2) @(posedge clk_i);
    bp_phase <= 1'b1;
    repeat (`HER_SLOTS + 1) send_her(0);
    repeat (4) @(posedge clk_i);
    bp_phase <= 1'b0;
    hold     <= 1'b0;
    // Feedback piles up behind a stalled NIC
    nic_stall <= 1'b1;
    for (int i = 0; i < 6; i++) begin
      send_her(1);
    end
    repeat (20) @(posedge clk_i);
    nic_stall <= 1'b0;
    wait_drained();
    repeat (2) @(posedge clk_i);
    $display("Summary: %0d errors, %0d HERs, %0d cycles", errors, msg_cnt - 1, cycles);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- sim.f
+incdir+include
source/pspin_sched_pkg.sv
source/her_queue.sv
source/cluster_dispatcher.sv
source/feedback_arbiter.sv
source/pspin_sched_top.sv
dv/tb_cluster_model.sv
dv/tb_pspin_sched.sv
